// File: Makefile
# Verilator build and run of the decode stage testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module decode_tb \
		-Mdir obj_dir -o decode_tb

# Passes only when the simulation output contains the pass message
run: compile
	./obj_dir/decode_tb | tee /dev/stderr | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir

// File: build.f
verilog/rv32_pkg.sv
verilog/decode_pkg.sv
verilog/reg_array.sv
verilog/reg_scoreboard.sv
verilog/decode_control.sv
verilog/issue_stage.sv
verilog/decode_top.sv
sim/decode_tb.sv

// File: sim/decode_tb.sv
/*
 * Table-driven testbench for decode_top with an execute-side model.
 * Every issued register write in the table has a matching writeback row,
 * otherwise the scoreboard would stall. Two runs, each after its own reset.
 */
`timescale 1ns/10ps

module decode_tb;

    typedef struct packed {
        logic [31:0] word;
        logic wb_en;
        rv32_pkg::reg_addr_t wb_addr;
        rv32_pkg::reg_value_t wb_value;
        rv32_pkg::reg_value_t exp_rs1;
        rv32_pkg::reg_value_t exp_rs2;
        logic issues;
        logic exp_halt;
        logic [7:0] exp_code;
    } row_t;

    localparam int num_rows = 14;
    localparam int split_row = 11;
    localparam int timeout_cycles = 40 + 20 * num_rows;

    logic clk = 1'b0;
    logic rst;
    logic instr_valid;
    logic instr_ready;
    decode_pkg::fetch_t instr;
    logic wb_valid;
    decode_pkg::writeback_t wb;
    logic exec_valid;
    logic exec_ready;
    decode_pkg::exec_cmd_t exec;
    logic exit_flag;
    logic [7:0] exit_code;

    row_t rows [num_rows];
    int cycle_cnt = 0;
    logic [7:0] exit_code_seen;

    decode_top u_dut (
        .clk(clk),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr_ready(instr_ready),
        .instr(instr),
        .wb_valid(wb_valid),
        .wb(wb),
        .exec_valid(exec_valid),
        .exec_ready(exec_ready),
        .exec(exec),
        .exit_flag(exit_flag),
        .exit_code(exit_code)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            fail_run("run exceeded its cycle limit");
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic compare_cmd(input decode_pkg::exec_cmd_t got,
                               input decode_pkg::exec_cmd_t exp);
        if (got.pc !== exp.pc) begin
            report_mismatch("exec.pc", got.pc, exp.pc);
        end
        if (got.fields !== exp.fields) begin
            report_mismatch("exec.fields", 32'(got.fields), 32'(exp.fields));
        end
        if (got.rs1_value !== exp.rs1_value) begin
            report_mismatch("exec.rs1_value", got.rs1_value, exp.rs1_value);
        end
        if (got.rs2_value !== exp.rs2_value) begin
            report_mismatch("exec.rs2_value", got.rs2_value, exp.rs2_value);
        end
        if (got.halt !== exp.halt) begin
            report_mismatch("exec.halt", 32'(got.halt), 32'(exp.halt));
        end
    endtask

    task automatic compare_exit(input logic got_flag, input logic [7:0] got_code,
                                input logic exp_flag, input logic [7:0] exp_code);
        if (got_flag !== exp_flag) begin
            report_mismatch("exit_flag", 32'(got_flag), 32'(exp_flag));
        end
        if (got_code !== exp_code) begin
            report_mismatch("exit_code", 32'(got_code), 32'(exp_code));
        end
    endtask

    function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // ECALL and EBREAK read a0 and a1 whatever their encoded fields hold
    function automatic rv32_pkg::fields_t expected_fields(input logic [31:0] word);
        rv32_pkg::fields_t f;
        f = rv32_pkg::fields_t'(word);
        if (f.opcode == rv32_pkg::opcode_system && f.funct3 == 3'b000) begin
            f.rs1 = 5'd10;
            f.rs2 = 5'd11;
        end
        return f;
    endfunction

    function automatic logic [31:0] pc_of(input int row);
        return 32'h0000_1000 + 32'(row) * 32'd4;
    endfunction

    function automatic row_t table_row(input logic [31:0] word, input logic wb_en,
                                       input logic [4:0] wb_addr, input logic [31:0] wb_value,
                                       input logic [31:0] rs1, input logic [31:0] rs2,
                                       input logic issues, input logic halt,
                                       input logic [7:0] code);
        return '{word: word, wb_en: wb_en, wb_addr: wb_addr, wb_value: wb_value,
                 exp_rs1: rs1, exp_rs2: rs2, issues: issues, exp_halt: halt,
                 exp_code: code};
    endfunction

    function automatic int next_cmd_row(input int from, input int last);
        int r;
        r = from;
        while (r <= last && !rows[r].issues) begin
            r++;
        end
        return r;
    endfunction

    task automatic fill_table();
        // First run: sources, writebacks, hazards, then EBREAK and dropped rows
        rows[0] = table_row(encode(7'd0, 5'd2, 5'd1, 3'd0, 5'd3, rv32_pkg::opcode_op),
                            1'b1, 5'd3, 32'h0000_1111, 32'h0, 32'h0, 1'b1, 1'b0, 8'h00);
        rows[1] = table_row(encode(7'd1, 5'd0, 5'd0, 3'd0, 5'd5, rv32_pkg::opcode_op_imm),
                            1'b1, 5'd5, 32'h5555_a5a5, 32'h0, 32'h0, 1'b1, 1'b0, 8'h00);
        rows[2] = table_row(encode(7'd0, 5'd3, 5'd5, 3'd0, 5'd6, rv32_pkg::opcode_op),
                            1'b1, 5'd6, 32'h6666_0006, 32'h5555_a5a5, 32'h0000_1111,
                            1'b1, 1'b0, 8'h00);
        // Write to x0 is discarded
        rows[3] = table_row(encode(7'd1, 5'd0, 5'd0, 3'd0, 5'd0, rv32_pkg::opcode_op_imm),
                            1'b1, 5'd0, 32'hdead_beef, 32'h0, 32'h0, 1'b1, 1'b0, 8'h00);
        rows[4] = table_row(encode(7'd0, 5'd6, 5'd0, 3'd0, 5'd7, rv32_pkg::opcode_op),
                            1'b1, 5'd7, 32'h0000_7777, 32'h0, 32'h6666_0006,
                            1'b1, 1'b0, 8'h00);
        rows[5] = table_row(encode(7'd0, 5'd7, 5'd5, 3'd2, 5'd0, rv32_pkg::opcode_store),
                            1'b0, 5'd0, 32'h0, 32'h5555_a5a5, 32'h0000_7777,
                            1'b1, 1'b0, 8'h00);
        rows[6] = table_row(encode(7'h12, 5'd0, 5'd0, 3'd0, 5'd10, rv32_pkg::opcode_lui),
                            1'b1, 5'd10, 32'h1234_56a7, 32'h0, 32'h0, 1'b1, 1'b0, 8'h00);
        rows[7] = table_row(encode(7'd2, 5'd0, 5'd3, 3'd0, 5'd11, rv32_pkg::opcode_op_imm),
                            1'b1, 5'd11, 32'h0000_0b0b, 32'h0000_1111, 32'h0,
                            1'b1, 1'b0, 8'h00);
        rows[8] = table_row(encode(7'd0, 5'd1, 5'd0, 3'd0, 5'd0, rv32_pkg::opcode_system),
                            1'b0, 5'd0, 32'h0, 32'h1234_56a7, 32'h0000_0b0b,
                            1'b1, 1'b1, 8'ha7);
        rows[9] = table_row(encode(7'd0, 5'd2, 5'd1, 3'd0, 5'd12, rv32_pkg::opcode_op),
                            1'b0, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 8'h00);
        rows[10] = table_row(encode(7'd0, 5'd3, 5'd3, 3'd0, 5'd13, rv32_pkg::opcode_op),
                             1'b0, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 8'h00);
        // Second run: registers read zero again, then an unknown opcode
        rows[11] = table_row(encode(7'd0, 5'd6, 5'd3, 3'd0, 5'd4, rv32_pkg::opcode_op),
                             1'b1, 5'd4, 32'h0000_0044, 32'h0, 32'h0, 1'b1, 1'b0, 8'h00);
        rows[12] = table_row(encode(7'd0, 5'd0, 5'd0, 3'd0, 5'd0, 7'h7f),
                             1'b0, 5'd0, 32'h0, 32'h0, 32'h0, 1'b1, 1'b1, 8'h01);
        rows[13] = table_row(encode(7'd0, 5'd4, 5'd4, 3'd0, 5'd5, rv32_pkg::opcode_op),
                             1'b0, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 8'h00);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        instr_valid <= 1'b0;
        instr <= '0;
        wb_valid <= 1'b0;
        wb <= '0;
        exec_ready <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Sweep holds instr_ready low for one cycle per register
    task automatic check_sweep();
        int low_cycles;
        low_cycles = 0;
        @(negedge clk);
        while (!instr_ready && low_cycles < 64) begin
            if (exec_valid) begin
                fail_run("exec_valid went high during the register sweep");
            end
            compare_exit(exit_flag, exit_code, 1'b0, 8'h00);
            low_cycles++;
            @(negedge clk);
        end
        if (low_cycles != 32) begin
            report_mismatch("instr_ready low cycles", low_cycles, 32);
        end
    endtask

    task automatic drive_rows(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            @(posedge clk);
            instr_valid <= 1'b1;
            instr <= '{pc: pc_of(i), word: rows[i].word};
            @(negedge clk);
            while (!instr_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    // Execute side: random stalls, in-order checks, one writeback per consumed row
    task automatic consume_rows(input int first, input int last);
        int row;
        int wb_row;
        logic held_valid;
        decode_pkg::exec_cmd_t held_cmd;
        decode_pkg::exec_cmd_t exp;
        row = next_cmd_row(first, last);
        wb_row = -1;
        held_valid = 1'b0;
        while (row <= last || wb_row >= 0) begin
            @(posedge clk);
            exec_ready <= ($urandom % 4) != 0;
            if (wb_row >= 0) begin
                wb_valid <= 1'b1;
                wb <= '{addr: rows[wb_row].wb_addr, value: rows[wb_row].wb_value};
                wb_row = -1;
            end else begin
                wb_valid <= 1'b0;
            end
            @(negedge clk);
            if (held_valid) begin
                if (!exec_valid) begin
                    fail_run("exec_valid dropped while a command was held");
                end
                compare_cmd(exec, held_cmd);
            end
            held_valid = exec_valid && !exec_ready;
            held_cmd = exec;
            if (exec_valid && exec_ready) begin
                if (row > last) begin
                    fail_run("command issued with no matching table row");
                end
                exp.pc = pc_of(row);
                exp.fields = expected_fields(rows[row].word);
                exp.rs1_value = rows[row].exp_rs1;
                exp.rs2_value = rows[row].exp_rs2;
                exp.halt = rows[row].exp_halt;
                compare_cmd(exec, exp);
                compare_exit(exit_flag, exit_code, rows[row].exp_halt, rows[row].exp_code);
                if (rows[row].exp_halt) begin
                    exit_code_seen = rows[row].exp_code;
                end
                if (rows[row].wb_en) begin
                    wb_row = row;
                end
                row = next_cmd_row(row + 1, last);
            end
        end
        @(posedge clk);
        wb_valid <= 1'b0;
        // Stall execute so any command issued after the exit stays visible
        exec_ready <= 1'b0;
    endtask

    // After an exit nothing more comes out and the code holds
    task automatic check_quiet(input logic [7:0] code);
        repeat (8) begin
            @(posedge clk);
            exec_ready <= 1'b1;
            @(negedge clk);
            if (exec_valid) begin
                fail_run("command issued after exit");
            end
            compare_exit(exit_flag, exit_code, 1'b1, code);
        end
    endtask

    task automatic run_rows(input int first, input int last);
        fork
            drive_rows(first, last);
            consume_rows(first, last);
        join
        check_quiet(exit_code_seen);
    endtask

    initial begin
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        wb_valid = 1'b0;
        wb = '0;
        exec_ready = 1'b1;
        exit_code_seen = 8'h00;
        void'($urandom(66));
        fill_table();
        apply_reset();
        check_sweep();
        run_rows(0, split_row - 1);
        apply_reset();
        check_sweep();
        run_rows(split_row, num_rows - 1);
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: verilog/decode_control.sv
/*
 * Decode control: reset sweep, hazard check, exit handling and
 * register file write arbitration. Writebacks arriving during the
 * sweep are dropped. After an exit every instruction is consumed.
 */
`timescale 1ns/10ps

module decode_control (
    input  logic clk,
    input  logic rst,

    input  logic instr_valid,
    output logic instr_ready,
    input  decode_pkg::fetch_t instr,

    input  logic wb_valid,
    input  decode_pkg::writeback_t wb,

    input  rv32_pkg::reg_value_t rs1_value,
    input  rv32_pkg::reg_value_t rs2_value,

    output logic clear,
    output rv32_pkg::reg_addr_t clear_addr,
    output logic issue,
    output rv32_pkg::reg_addr_t issue_rd,
    output logic retire,
    output rv32_pkg::reg_addr_t retire_rd,
    output rv32_pkg::reg_addr_t rs1,
    output rv32_pkg::reg_addr_t rs2,
    input  decode_pkg::reg_status_t rs1_pending,
    input  decode_pkg::reg_status_t rs2_pending,
    input  decode_pkg::reg_status_t rd_pending,

    output logic rf_wr_en,
    output rv32_pkg::reg_addr_t rf_wr_addr,
    output rv32_pkg::reg_value_t rf_wr_data,
    output rv32_pkg::reg_addr_t rf_rs1,
    output rv32_pkg::reg_addr_t rf_rs2,

    output logic cmd_valid,
    input  logic cmd_ready,
    output decode_pkg::exec_cmd_t cmd,

    output logic exit_flag,
    output logic [7:0] exit_code
);

    decode_pkg::decode_state_t state, next_state;
    rv32_pkg::reg_addr_t sweep_cnt;
    rv32_pkg::fields_t fields;
    logic is_env, is_ebreak, illegal;
    logic writes_rd, uses_rs1, uses_rs2;
    logic hazard_free, take;

    // ECALL and EBREAK take their operands from a0 and a1
    always_comb begin
        fields = rv32_pkg::fields_t'(instr.word);
        is_env = fields.opcode == rv32_pkg::opcode_system &&
                 fields.funct3 == rv32_pkg::funct3_sys_env;
        if (is_env) begin
            fields.rs1 = rv32_pkg::abi_a0;
            fields.rs2 = rv32_pkg::abi_a1;
        end
    end

    // funct12 from the raw word, rs2 may have been replaced above
    assign is_ebreak = is_env && instr.word[31:20] == rv32_pkg::funct12_ebreak;

    // Operand usage per opcode
    always_comb begin
        illegal = 1'b0;
        writes_rd = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (fields.opcode)
            rv32_pkg::opcode_lui, rv32_pkg::opcode_auipc, rv32_pkg::opcode_jal: begin
                writes_rd = 1'b1;
            end
            rv32_pkg::opcode_jalr, rv32_pkg::opcode_load, rv32_pkg::opcode_op_imm: begin
                writes_rd = 1'b1;
                uses_rs1 = 1'b1;
            end
            rv32_pkg::opcode_op: begin
                writes_rd = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            rv32_pkg::opcode_branch, rv32_pkg::opcode_store: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            rv32_pkg::opcode_system: begin
                uses_rs1 = is_env;
                uses_rs2 = is_env;
            end
            rv32_pkg::opcode_misc_mem: begin
                illegal = 1'b0;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // x0 never has a write outstanding
    assign hazard_free = (!uses_rs1 || fields.rs1 == '0 || rs1_pending == '0) &&
                         (!uses_rs2 || fields.rs2 == '0 || rs2_pending == '0) &&
                         (!writes_rd || fields.rd == '0 ||
                          rd_pending < decode_pkg::status_max);

    assign cmd_valid = state == decode_pkg::decode_normal && instr_valid && hazard_free;
    assign take = cmd_valid && cmd_ready;
    assign instr_ready = state == decode_pkg::decode_exit ||
                         (state == decode_pkg::decode_normal && hazard_free && cmd_ready);

    assign cmd.pc = instr.pc;
    assign cmd.fields = fields;
    assign cmd.rs1_value = rs1_value;
    assign cmd.rs2_value = rs2_value;
    assign cmd.halt = is_ebreak || illegal;

    assign rs1 = fields.rs1;
    assign rs2 = fields.rs2;
    assign rf_rs1 = fields.rs1;
    assign rf_rs2 = fields.rs2;

    // Scoreboard strobes
    assign clear = state == decode_pkg::decode_reset;
    assign clear_addr = sweep_cnt;
    assign issue = take && writes_rd && fields.rd != '0;
    assign issue_rd = fields.rd;
    assign retire = !clear && wb_valid && wb.addr != '0;
    assign retire_rd = wb.addr;

    // Sweep owns the write port until it ends
    always_comb begin
        if (clear) begin
            rf_wr_en = 1'b1;
            rf_wr_addr = sweep_cnt;
            rf_wr_data = '0;
        end else begin
            rf_wr_en = wb_valid && wb.addr != '0;
            rf_wr_addr = wb.addr;
            rf_wr_data = wb.value;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            decode_pkg::decode_reset: begin
                if (sweep_cnt == rv32_pkg::reg_addr_t'(rv32_pkg::num_regs - 1)) begin
                    next_state = decode_pkg::decode_normal;
                end
            end
            decode_pkg::decode_normal: begin
                if (take && cmd.halt) begin
                    next_state = decode_pkg::decode_exit;
                end
            end
            decode_pkg::decode_exit: begin
                next_state = decode_pkg::decode_exit;
            end
            default: begin
                next_state = decode_pkg::decode_reset;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= decode_pkg::decode_reset;
            sweep_cnt <= '0;
            exit_code <= '0;
        end else begin
            state <= next_state;
            if (clear) begin
                sweep_cnt <= sweep_cnt + 5'd1;
            end
            // EBREAK exits with the low byte of a0
            if (take && is_ebreak) begin
                exit_code <= rs1_value[7:0];
            end else if (take && illegal) begin
                exit_code <= decode_pkg::exit_code_illegal;
            end
        end
    end

    assign exit_flag = state == decode_pkg::decode_exit;

    // Nothing issues during the sweep
    assert property (@(posedge clk) disable iff (rst)
        state == decode_pkg::decode_reset |-> !cmd_valid);

endmodule

// File: verilog/decode_pkg.sv
/*
 * Decode stage types: state, scoreboard counters and stream payloads.
 * Status counters are 2 bits wide, so at most status_max writes
 * may be outstanding on one register.
 */
package decode_pkg;

    // Stage state
    typedef enum logic [1:0] {
        decode_reset = 2'd0,
        decode_normal = 2'd1,
        decode_exit = 2'd2
    } decode_state_t;

    // Per-register write counter, compared front against rear
    typedef logic [1:0] reg_status_t;

    // Count at which a destination can take no more writes
    localparam reg_status_t status_max = 2'd3;

    // Fetched instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
    } fetch_t;

    // Result returning from execute
    typedef struct packed {
        rv32_pkg::reg_addr_t addr;
        rv32_pkg::reg_value_t value;
    } writeback_t;

    // Command sent to execute
    typedef struct packed {
        logic [31:0] pc;
        rv32_pkg::fields_t fields;
        rv32_pkg::reg_value_t rs1_value;
        rv32_pkg::reg_value_t rs2_value;
        logic halt;
    } exec_cmd_t;

    // Exit code for an unknown opcode
    localparam logic [7:0] exit_code_illegal = 8'd1;

endpackage

// File: verilog/decode_top.sv
/*
 * Decode and issue stage of an in-order RV32I core.
 * Writebacks are always accepted. exit_flag is a level that holds
 * until the next reset.
 */
`timescale 1ns/10ps

module decode_top (
    input  logic clk,
    input  logic rst,

    input  logic instr_valid,
    output logic instr_ready,
    input  decode_pkg::fetch_t instr,

    input  logic wb_valid,
    input  decode_pkg::writeback_t wb,

    output logic exec_valid,
    input  logic exec_ready,
    output decode_pkg::exec_cmd_t exec,

    output logic exit_flag,
    output logic [7:0] exit_code
);

    logic clear, issue, retire;
    rv32_pkg::reg_addr_t clear_addr, issue_rd, retire_rd, rs1, rs2;
    decode_pkg::reg_status_t rs1_pending, rs2_pending, rd_pending;

    logic rf_wr_en;
    rv32_pkg::reg_addr_t rf_wr_addr;
    rv32_pkg::reg_value_t rf_wr_data;
    rv32_pkg::reg_addr_t rf_rd_addr [2];
    rv32_pkg::reg_value_t rf_rd_data [2];

    logic cmd_valid, cmd_ready;
    decode_pkg::exec_cmd_t cmd;

    decode_control u_control (
        .clk(clk),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr_ready(instr_ready),
        .instr(instr),
        .wb_valid(wb_valid),
        .wb(wb),
        .rs1_value(rf_rd_data[0]),
        .rs2_value(rf_rd_data[1]),
        .clear(clear),
        .clear_addr(clear_addr),
        .issue(issue),
        .issue_rd(issue_rd),
        .retire(retire),
        .retire_rd(retire_rd),
        .rs1(rs1),
        .rs2(rs2),
        .rs1_pending(rs1_pending),
        .rs2_pending(rs2_pending),
        .rd_pending(rd_pending),
        .rf_wr_en(rf_wr_en),
        .rf_wr_addr(rf_wr_addr),
        .rf_wr_data(rf_wr_data),
        .rf_rs1(rf_rd_addr[0]),
        .rf_rs2(rf_rd_addr[1]),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd(cmd),
        .exit_flag(exit_flag),
        .exit_code(exit_code)
    );

    reg_scoreboard u_scoreboard (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .clear_addr(clear_addr),
        .issue(issue),
        .issue_rd(issue_rd),
        .retire(retire),
        .retire_rd(retire_rd),
        .rs1(rs1),
        .rs2(rs2),
        .rs1_pending(rs1_pending),
        .rs2_pending(rs2_pending),
        .rd_pending(rd_pending)
    );

    // Register file
    reg_array #(
        .T(rv32_pkg::reg_value_t),
        .read_ports(2)
    ) u_regfile (
        .clk(clk),
        .wr_en(rf_wr_en),
        .wr_addr(rf_wr_addr),
        .wr_data(rf_wr_data),
        .wr_q(),
        .rd_addr(rf_rd_addr),
        .rd_data(rf_rd_data)
    );

    issue_stage u_issue (
        .clk(clk),
        .rst(rst),
        .in_valid(cmd_valid),
        .in_ready(cmd_ready),
        .in_cmd(cmd),
        .out_valid(exec_valid),
        .out_ready(exec_ready),
        .out_cmd(exec)
    );

endmodule

// File: verilog/issue_stage.sv
/*
 * One-entry registered valid/ready stage for execute commands.
 * Full throughput: a new command is taken in the cycle the held one leaves.
 */
`timescale 1ns/10ps

module issue_stage (
    input  logic clk,
    input  logic rst,

    input  logic in_valid,
    output logic in_ready,
    input  decode_pkg::exec_cmd_t in_cmd,

    output logic out_valid,
    input  logic out_ready,
    output decode_pkg::exec_cmd_t out_cmd
);

    logic full;
    decode_pkg::exec_cmd_t held;

    // Room when empty or when the held command drains this cycle
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held <= in_cmd;
        end
    end

    assign out_valid = full;
    assign out_cmd = held;

    // Held command stays put under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_cmd));

endmodule

// File: verilog/reg_array.sv
/*
 * 32-entry flip-flop array, one write port and read_ports read ports.
 * Reads are combinational and see a write only after the clock edge.
 * Contents are not reset, the owner must sweep them.
 */
`timescale 1ns/10ps

module reg_array #(
    parameter type T = logic [31:0],
    parameter int read_ports = 2
) (
    input  logic clk,

    input  logic wr_en,
    input  rv32_pkg::reg_addr_t wr_addr,
    input  T wr_data,
    output T wr_q,

    input  rv32_pkg::reg_addr_t rd_addr [read_ports],
    output T rd_data [read_ports]
);

    T mem [rv32_pkg::num_regs];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Current content at the write address, used for read-modify-write
    assign wr_q = mem[wr_addr];

    for (genvar i = 0; i < read_ports; i++) begin : g_read
        assign rd_data[i] = mem[rd_addr[i]];
    end

endmodule

// File: verilog/reg_scoreboard.sv
/*
 * Front/rear write counters per register.
 * Pending count is front minus rear, modulo the counter width.
 * Clear has priority over issue and retire.
 */
`timescale 1ns/10ps

module reg_scoreboard (
    input  logic clk,
    input  logic rst,

    input  logic clear,
    input  rv32_pkg::reg_addr_t clear_addr,

    input  logic issue,
    input  rv32_pkg::reg_addr_t issue_rd,

    input  logic retire,
    input  rv32_pkg::reg_addr_t retire_rd,

    input  rv32_pkg::reg_addr_t rs1,
    input  rv32_pkg::reg_addr_t rs2,

    output decode_pkg::reg_status_t rs1_pending,
    output decode_pkg::reg_status_t rs2_pending,
    output decode_pkg::reg_status_t rd_pending
);

    decode_pkg::reg_status_t front_rd, rear_wb;
    decode_pkg::reg_status_t front_wr_data, rear_wr_data;
    rv32_pkg::reg_addr_t front_wr_addr, rear_wr_addr;
    rv32_pkg::reg_addr_t front_rd_addr [2];
    rv32_pkg::reg_addr_t rear_rd_addr [3];
    decode_pkg::reg_status_t front_q [2];
    decode_pkg::reg_status_t rear_q [3];

    // Front counts writes handed out by decode
    assign front_wr_addr = clear ? clear_addr : issue_rd;
    assign front_wr_data = clear ? '0 : front_rd + 2'd1;
    assign front_rd_addr[0] = rs1;
    assign front_rd_addr[1] = rs2;

    reg_array #(
        .T(decode_pkg::reg_status_t),
        .read_ports(2)
    ) u_front (
        .clk(clk),
        .wr_en(clear || issue),
        .wr_addr(front_wr_addr),
        .wr_data(front_wr_data),
        .wr_q(front_rd),
        .rd_addr(front_rd_addr),
        .rd_data(front_q)
    );

    // Rear counts writes that came back
    assign rear_wr_addr = clear ? clear_addr : retire_rd;
    assign rear_wr_data = clear ? '0 : rear_wb + 2'd1;
    assign rear_rd_addr[0] = issue_rd;
    assign rear_rd_addr[1] = rs1;
    assign rear_rd_addr[2] = rs2;

    reg_array #(
        .T(decode_pkg::reg_status_t),
        .read_ports(3)
    ) u_rear (
        .clk(clk),
        .wr_en(clear || retire),
        .wr_addr(rear_wr_addr),
        .wr_data(rear_wr_data),
        .wr_q(rear_wb),
        .rd_addr(rear_rd_addr),
        .rd_data(rear_q)
    );

    assign rd_pending = front_rd - rear_q[0];
    assign rs1_pending = front_q[0] - rear_q[1];
    assign rs2_pending = front_q[1] - rear_q[2];

    // Decode must hold a destination that is already full
    assert property (@(posedge clk) disable iff (rst)
        issue && !clear |-> rd_pending != decode_pkg::status_max);

endmodule

// File: verilog/rv32_pkg.sv
/*
 * RV32I base ISA definitions shared by the decode stage.
 * Only the base integer opcodes are listed. M, F and CSR extensions
 * are not decoded here.
 */
package rv32_pkg;

    // Register file geometry
    localparam int num_regs = 32;

    typedef logic [4:0] reg_addr_t;
    typedef logic [31:0] reg_value_t;

    // Standard R-type layout, which also covers the fixed fields of the
    // other formats. funct12 is {funct7, rs2}
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t rs2;
        reg_addr_t rs1;
        logic [2:0] funct3;
        reg_addr_t rd;
        logic [6:0] opcode;
    } fields_t;

    // Major opcodes
    localparam logic [6:0] opcode_lui = 7'b0110111;
    localparam logic [6:0] opcode_auipc = 7'b0010111;
    localparam logic [6:0] opcode_jal = 7'b1101111;
    localparam logic [6:0] opcode_jalr = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_load = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] opcode_misc_mem = 7'b0001111;
    localparam logic [6:0] opcode_system = 7'b1110011;

    // Environment call and break share funct3, funct12 tells them apart
    localparam logic [2:0] funct3_sys_env = 3'b000;
    localparam logic [11:0] funct12_ecall = 12'h000;
    localparam logic [11:0] funct12_ebreak = 12'h001;

    // ABI argument registers
    localparam reg_addr_t abi_a0 = 5'd10;
    localparam reg_addr_t abi_a1 = 5'd11;

endpackage
